// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  bj_kind_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [1:0]  mem_width_t;
    typedef logic [2:0]  imm_type_t;

    // RV32I major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    localparam bj_kind_t BJ_NONE = 4'd0;
    localparam bj_kind_t BJ_BEQ  = 4'd1;
    localparam bj_kind_t BJ_BNE  = 4'd2;
    localparam bj_kind_t BJ_BLT  = 4'd3;
    localparam bj_kind_t BJ_BGE  = 4'd4;
    localparam bj_kind_t BJ_BLTU = 4'd5;
    localparam bj_kind_t BJ_BGEU = 4'd6;
    localparam bj_kind_t BJ_JAL  = 4'd7;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    // Matches funct3[1:0] of loads and stores
    localparam mem_width_t MEM_BYTE = 2'd0;
    localparam mem_width_t MEM_HALF = 2'd1;
    localparam mem_width_t MEM_WORD = 2'd2;

    localparam imm_type_t IMM_I = 3'd0;
    localparam imm_type_t IMM_S = 3'd1;
    localparam imm_type_t IMM_B = 3'd2;
    localparam imm_type_t IMM_U = 3'd3;
    localparam imm_type_t IMM_J = 3'd4;

endpackage

`default_nettype wire

// ==== hw/ex_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface ex_ctrl_if;
    import core_pkg::*;

    alu_op_t    alu_op;
    bj_kind_t   bj_kind;
    wb_sel_t    wb_sel;
    mem_width_t mem_width;
    logic       mem_rd;
    logic       mem_wr;
    logic       mem_unsigned;
    logic       reg_wr;
    logic       jalr;
    logic       use_imm;
    // Operand A source, PC for AUIPC/JAL, zero for LUI
    logic       pc_as_a;
    logic       zero_a;
    logic       illegal;
    imm_type_t  imm_type;

    modport dec (
        output alu_op, bj_kind, wb_sel, mem_width, mem_rd, mem_wr, mem_unsigned,
               reg_wr, jalr, use_imm, pc_as_a, zero_a, illegal, imm_type
    );

    modport stage (
        input alu_op, bj_kind, wb_sel, mem_width, mem_rd, mem_wr, mem_unsigned,
              reg_wr, jalr, use_imm, pc_as_a, zero_a, illegal, imm_type
    );

endinterface

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file #(
    parameter int NUM_REGS = 32
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  wire                 we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t regs [NUM_REGS];

    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0 || int'(addr) >= NUM_REGS) begin
            value = '0;
        end else if (we && waddr == addr) begin
            // Same-cycle write is forwarded
            value = wdata;
        end else begin
            value = regs[addr[IDX_W-1:0]];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0 && int'(waddr) < NUM_REGS) begin
            regs[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0));

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input core_pkg::word_t instr,
    ex_ctrl_if.dec         ctrl
);
    import core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct30;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct30 = instr[30];

    // SUB only exists in the register form
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt,
                                                input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic bj_kind_t branch_kind(input logic [2:0] f3);
        bj_kind_t kind;
        case (f3)
            3'b000:  kind = BJ_BEQ;
            3'b001:  kind = BJ_BNE;
            3'b100:  kind = BJ_BLT;
            3'b101:  kind = BJ_BGE;
            3'b110:  kind = BJ_BLTU;
            3'b111:  kind = BJ_BGEU;
            default: kind = BJ_NONE;
        endcase
        return kind;
    endfunction

    always_comb begin
        ctrl.alu_op       = ALU_ADD;
        ctrl.bj_kind      = BJ_NONE;
        ctrl.wb_sel       = WB_ALU;
        ctrl.mem_width    = MEM_BYTE;
        ctrl.mem_rd       = 1'b0;
        ctrl.mem_wr       = 1'b0;
        ctrl.mem_unsigned = 1'b0;
        ctrl.reg_wr       = 1'b0;
        ctrl.jalr         = 1'b0;
        ctrl.use_imm      = 1'b0;
        ctrl.pc_as_a      = 1'b0;
        ctrl.zero_a       = 1'b0;
        ctrl.illegal      = 1'b0;
        ctrl.imm_type     = IMM_I;

        case (opcode)
            OP_LUI: begin
                ctrl.alu_op   = ALU_PASS_B;
                ctrl.reg_wr   = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.zero_a   = 1'b1;
                ctrl.imm_type = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.reg_wr   = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.pc_as_a  = 1'b1;
                ctrl.imm_type = IMM_U;
            end
            OP_JAL: begin
                ctrl.bj_kind  = BJ_JAL;
                ctrl.wb_sel   = WB_PC4;
                ctrl.reg_wr   = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.pc_as_a  = 1'b1;
                ctrl.imm_type = IMM_J;
            end
            OP_JALR: begin
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_wr  = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.use_imm = 1'b1;
            end
            OP_BRANCH: begin
                // Compare is done by the ALU on rs1 and rs2
                ctrl.alu_op   = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
                ctrl.bj_kind  = branch_kind(funct3);
                ctrl.imm_type = IMM_B;
            end
            OP_LOAD: begin
                ctrl.wb_sel       = WB_MEM;
                ctrl.mem_width    = funct3[1:0];
                ctrl.mem_unsigned = funct3[2];
                ctrl.mem_rd       = 1'b1;
                ctrl.reg_wr       = 1'b1;
                ctrl.use_imm      = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_width = funct3[1:0];
                ctrl.mem_wr    = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm_type  = IMM_S;
            end
            OP_IMM: begin
                ctrl.alu_op  = alu_from_funct3(funct3, funct30, 1'b0);
                ctrl.reg_wr  = 1'b1;
                ctrl.use_imm = 1'b1;
            end
            OP_REG: begin
                ctrl.alu_op = alu_from_funct3(funct3, funct30, 1'b1);
                ctrl.reg_wr = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  core_pkg::word_t     instr,
    input  core_pkg::imm_type_t imm_type,
    output core_pkg::word_t     imm
);
    import core_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // Branch and jump offsets are in halfwords, bit 0 is always zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (imm_type)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/load_use_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_use_detect (
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  wire                 mem_rd_ex,
    input  core_pkg::reg_addr_t rd_ex,
    output logic                stall
);
    logic rd_live;
    logic src_match;

    // A load into x0 produces nothing to wait for
    assign rd_live = mem_rd_ex && (rd_ex != '0);

    // Both fields are compared even when the format has no rs2
    assign src_match = (rd_ex == rs1) || (rd_ex == rs2);

    assign stall = rd_live && src_match;

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  bubble,
    input  core_pkg::word_t      pc,
    input  core_pkg::word_t      instr,
    input  core_pkg::word_t      rs1_data,
    input  core_pkg::word_t      rs2_data,
    input  core_pkg::word_t      imm,
    ex_ctrl_if.stage             ctrl,
    output core_pkg::word_t      op_a_ex,
    output core_pkg::word_t      rs2_data_ex,
    output core_pkg::word_t      imm_ex,
    output core_pkg::word_t      pc_ex,
    output core_pkg::reg_addr_t  rd_ex,
    output core_pkg::reg_addr_t  rs1_ex,
    output core_pkg::reg_addr_t  rs2_ex,
    output core_pkg::alu_op_t    alu_op_ex,
    output core_pkg::bj_kind_t   bj_kind_ex,
    output core_pkg::wb_sel_t    wb_sel_ex,
    output core_pkg::mem_width_t mem_width_ex,
    output logic                 mem_rd_ex,
    output logic                 mem_wr_ex,
    output logic                 mem_unsigned_ex,
    output logic                 reg_wr_ex,
    output logic                 jalr_ex,
    output logic                 use_imm_ex,
    output logic                 illegal_ex
);
    import core_pkg::*;

    localparam int EX_W = 4 * $bits(word_t) + 3 * $bits(reg_addr_t) + $bits(alu_op_t)
                        + $bits(bj_kind_t) + $bits(wb_sel_t) + $bits(mem_width_t) + 7;

    word_t           op_a;
    logic [EX_W-1:0] ex_d;
    logic [EX_W-1:0] ex_q;

    always_comb begin
        if (ctrl.pc_as_a) begin
            op_a = pc;
        end else if (ctrl.zero_a) begin
            op_a = '0;
        end else begin
            op_a = rs1_data;
        end
    end

    // Field order must match the unpacking below
    assign ex_d = bubble ? '0 : {op_a, rs2_data, imm, pc,
                                 instr[11:7], instr[19:15], instr[24:20],
                                 ctrl.alu_op, ctrl.bj_kind, ctrl.wb_sel, ctrl.mem_width,
                                 ctrl.mem_rd, ctrl.mem_wr, ctrl.mem_unsigned, ctrl.reg_wr,
                                 ctrl.jalr, ctrl.use_imm, ctrl.illegal};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

    assign {op_a_ex, rs2_data_ex, imm_ex, pc_ex,
            rd_ex, rs1_ex, rs2_ex,
            alu_op_ex, bj_kind_ex, wb_sel_ex, mem_width_ex,
            mem_rd_ex, mem_wr_ex, mem_unsigned_ex, reg_wr_ex,
            jalr_ex, use_imm_ex, illegal_ex} = ex_q;

    a_bubble_no_side_effect: assert property (@(posedge clk) disable iff (!rst_n)
        bubble |=> !reg_wr_ex && !mem_wr_ex && !mem_rd_ex);

endmodule

`default_nettype wire

// ==== hw/decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_top #(
    parameter int NUM_REGS = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  flush,
    input  core_pkg::word_t      instr,
    input  core_pkg::word_t      pc,
    input  wire                  wb_we,
    input  core_pkg::reg_addr_t  wb_addr,
    input  core_pkg::word_t      wb_data,
    output core_pkg::word_t      op_a_ex,
    output core_pkg::word_t      rs2_data_ex,
    output core_pkg::word_t      imm_ex,
    output core_pkg::word_t      pc_ex,
    output core_pkg::reg_addr_t  rd_ex,
    output core_pkg::reg_addr_t  rs1_ex,
    output core_pkg::reg_addr_t  rs2_ex,
    output core_pkg::alu_op_t    alu_op_ex,
    output core_pkg::bj_kind_t   bj_kind_ex,
    output core_pkg::wb_sel_t    wb_sel_ex,
    output core_pkg::mem_width_t mem_width_ex,
    output logic                 mem_rd_ex,
    output logic                 mem_wr_ex,
    output logic                 mem_unsigned_ex,
    output logic                 reg_wr_ex,
    output logic                 jalr_ex,
    output logic                 use_imm_ex,
    output logic                 illegal_ex,
    output logic                 stall
);
    import core_pkg::*;

    word_t rs1_data;
    word_t rs2_data;
    word_t imm;
    logic  bubble;

    ex_ctrl_if ctrl_bus ();

    assign bubble = stall || flush;

    register_file #(.NUM_REGS(NUM_REGS)) u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .we       (wb_we),
        .waddr    (wb_addr),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    instr_decoder u_instr_decoder (
        .instr (instr),
        .ctrl  (ctrl_bus.dec)
    );

    imm_gen u_imm_gen (
        .instr    (instr),
        .imm_type (ctrl_bus.imm_type),
        .imm      (imm)
    );

    load_use_detect u_load_use_detect (
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .mem_rd_ex (mem_rd_ex),
        .rd_ex     (rd_ex),
        .stall     (stall)
    );

    decode_stage u_decode_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .bubble          (bubble),
        .pc              (pc),
        .instr           (instr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .imm             (imm),
        .ctrl            (ctrl_bus.stage),
        .op_a_ex         (op_a_ex),
        .rs2_data_ex     (rs2_data_ex),
        .imm_ex          (imm_ex),
        .pc_ex           (pc_ex),
        .rd_ex           (rd_ex),
        .rs1_ex          (rs1_ex),
        .rs2_ex          (rs2_ex),
        .alu_op_ex       (alu_op_ex),
        .bj_kind_ex      (bj_kind_ex),
        .wb_sel_ex       (wb_sel_ex),
        .mem_width_ex    (mem_width_ex),
        .mem_rd_ex       (mem_rd_ex),
        .mem_wr_ex       (mem_wr_ex),
        .mem_unsigned_ex (mem_unsigned_ex),
        .reg_wr_ex       (reg_wr_ex),
        .jalr_ex         (jalr_ex),
        .use_imm_ex      (use_imm_ex),
        .illegal_ex      (illegal_ex)
    );

endmodule

`default_nettype wire

// ==== dv/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected decode results, taken from the RV32I encoding tables

function automatic word_t expected_imm(input word_t ins);
    word_t v;
    case (ins[6:0])
        OP_STORE:         v = {{21{ins[31]}}, ins[30:25], ins[11:7]};
        OP_BRANCH:        v = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        OP_LUI, OP_AUIPC: v = {ins[31:12], 12'h000};
        OP_JAL:           v = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        default:          v = {{21{ins[31]}}, ins[30:20]};
    endcase
    return v;
endfunction

function automatic alu_op_t expected_alu_op(input word_t ins);
    alu_op_t op;
    logic    is_reg;
    is_reg = (ins[6:0] == OP_REG);
    op     = ALU_ADD;
    if (ins[6:0] == OP_LUI) begin
        op = ALU_PASS_B;
    end else if (is_reg || ins[6:0] == OP_IMM) begin
        case (ins[14:12])
            3'd0:    op = (is_reg && ins[30]) ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = ins[30] ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end
    return op;
endfunction

function automatic bj_kind_t expected_bj_kind(input word_t ins);
    bj_kind_t k;
    k = BJ_NONE;
    if (ins[6:0] == OP_JAL) begin
        k = BJ_JAL;
    end else if (ins[6:0] == OP_BRANCH) begin
        case (ins[14:12])
            3'd0:    k = BJ_BEQ;
            3'd1:    k = BJ_BNE;
            3'd4:    k = BJ_BLT;
            3'd5:    k = BJ_BGE;
            3'd6:    k = BJ_BLTU;
            3'd7:    k = BJ_BGEU;
            default: k = BJ_NONE;
        endcase
    end
    return k;
endfunction

function automatic logic expected_reg_wr(input word_t ins);
    return ins[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG};
endfunction

// Immediate feeds ALU operand B for everything but register ops and branches
function automatic logic expected_use_imm(input word_t ins);
    return ins[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE, OP_IMM};
endfunction

`endif

// ==== dv/tb_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decode_top;
    import core_pkg::*;

    `include "decode_model.svh"

    localparam int HALF_PERIOD = 20;
    localparam int SETTLE      = 5;
    localparam int STALL_LIMIT = 8;

    logic       clk;
    logic       rst_n;
    logic       flush;
    word_t      instr;
    word_t      pc;
    logic       wb_we;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    word_t      op_a_ex;
    word_t      rs2_data_ex;
    word_t      imm_ex;
    word_t      pc_ex;
    reg_addr_t  rd_ex;
    reg_addr_t  rs1_ex;
    reg_addr_t  rs2_ex;
    alu_op_t    alu_op_ex;
    bj_kind_t   bj_kind_ex;
    wb_sel_t    wb_sel_ex;
    mem_width_t mem_width_ex;
    logic       mem_rd_ex;
    logic       mem_wr_ex;
    logic       mem_unsigned_ex;
    logic       reg_wr_ex;
    logic       jalr_ex;
    logic       use_imm_ex;
    logic       illegal_ex;
    logic       stall;

    int    checks;
    int    errors;
    int    stalls;
    word_t shadow [32];

    always #HALF_PERIOD clk = ~clk;

    decode_top #(.NUM_REGS(32)) u_decode_top (.*);

    task automatic record(input logic ok, input string msg);
        checks++;
        if (!ok) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        record(got === exp, $sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        record(got === exp, $sformatf("%s got x%0d expected x%0d", what, got, exp));
    endtask

    task automatic check_alu(input string what, input alu_op_t got, input alu_op_t exp);
        record(got === exp, $sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_bj(input string what, input bj_kind_t got, input bj_kind_t exp);
        record(got === exp, $sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_width(input string what, input mem_width_t got, input mem_width_t exp);
        record(got === exp, $sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_wb(input string what, input wb_sel_t got, input wb_sel_t exp);
        record(got === exp, $sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        record(got === exp, $sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_ex_cleared(input string what);
        check_word({what, " op_a"}, op_a_ex, '0);
        check_word({what, " rs2_data"}, rs2_data_ex, '0);
        check_word({what, " imm"}, imm_ex, '0);
        check_word({what, " pc"}, pc_ex, '0);
        check_addr({what, " rd|rs1|rs2"}, rd_ex | rs1_ex | rs2_ex, '0);
        check_alu({what, " alu_op"}, alu_op_ex, '0);
        check_bj({what, " bj_kind"}, bj_kind_ex, '0);
        check_bit({what, " control"}, |{wb_sel_ex, mem_width_ex, mem_rd_ex, mem_wr_ex,
                  mem_unsigned_ex, reg_wr_ex, jalr_ex, use_imm_ex, illegal_ex}, 1'b0);
    endtask

    function automatic word_t r_type(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(input opcode_t op, input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Starts on a falling edge and returns on the falling edge after the instruction enters EX
    task automatic issue(input word_t ins, input word_t addr, output int n_stall);
        instr   = ins;
        pc      = addr;
        n_stall = 0;
        #SETTLE;
        while (stall) begin
            n_stall++;
            if (n_stall > STALL_LIMIT) begin
                $display("Timeout: stall stayed high for more than %0d cycles", STALL_LIMIT);
                $display("Test failed");
                $finish;
            end
            @(negedge clk);
            check_ex_cleared("bubble");
            #SETTLE;
        end
        @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        wb_we   = 1'b1;
        wb_addr = addr;
        wb_data = data;
        @(negedge clk);
        wb_we = 1'b0;
        if (addr != '0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        $display("%-16s %0d errors", name, errors - start_errors);
    endtask

    task automatic test_reset();
        int e0;
        e0    = errors;
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_ex_cleared("reset");
        check_bit("reset stall", stall, 1'b0);
        rst_n = 1'b1;
        finish_test("reset", e0);
    endtask

    task automatic test_regfile();
        int    e0;
        int    i;
        word_t v;
        e0 = errors;
        for (i = 1; i < 32; i++) begin
            write_reg(reg_addr_t'(i), $urandom);
        end
        for (i = 1; i < 32; i++) begin
            issue(r_type(3'd0, 1'b0, 5'd1, reg_addr_t'(i), reg_addr_t'(32 - i)), 32'h100, stalls);
            check_word("rs1 read", op_a_ex, shadow[i]);
            check_word("rs2 read", rs2_data_ex, shadow[32 - i]);
        end
        write_reg(5'd0, 32'hffff_ffff);
        issue(r_type(3'd0, 1'b0, 5'd1, 5'd0, 5'd0), 32'h104, stalls);
        check_word("x0 rs1", op_a_ex, '0);
        check_word("x0 rs2", rs2_data_ex, '0);
        // Write and read of x9 in the same cycle
        v       = $urandom;
        wb_we   = 1'b1;
        wb_addr = 5'd9;
        wb_data = v;
        issue(r_type(3'd0, 1'b0, 5'd1, 5'd9, 5'd9), 32'h108, stalls);
        wb_we     = 1'b0;
        shadow[9] = v;
        check_word("bypass rs1", op_a_ex, v);
        check_word("bypass rs2", rs2_data_ex, v);
        finish_test("register file", e0);
    endtask

    task automatic test_alu_decode();
        int    e0;
        int    i;
        word_t ins;
        e0 = errors;
        for (i = 0; i < 16; i++) begin
            ins = r_type(i[2:0], i[3], 5'd3, 5'd4, 5'd5);
            issue(ins, 32'h200, stalls);
            check_alu("OP_REG alu_op", alu_op_ex, expected_alu_op(ins));
            check_bit("OP_REG reg_wr", reg_wr_ex, expected_reg_wr(ins));
            check_bit("OP_REG use_imm", use_imm_ex, expected_use_imm(ins));
            check_addr("OP_REG rd", rd_ex, 5'd3);
            check_addr("OP_REG rs1", rs1_ex, 5'd4);
            check_addr("OP_REG rs2", rs2_ex, 5'd5);
            check_word("OP_REG op_a", op_a_ex, shadow[4]);
            check_word("OP_REG rs2", rs2_data_ex, shadow[5]);
            ins = i_type(OP_IMM, i[2:0], 5'd6, 5'd7, 12'($urandom));
            issue(ins, 32'h204, stalls);
            check_alu("OP_IMM alu_op", alu_op_ex, expected_alu_op(ins));
            check_bit("OP_IMM reg_wr", reg_wr_ex, expected_reg_wr(ins));
            check_bit("OP_IMM use_imm", use_imm_ex, expected_use_imm(ins));
            check_addr("OP_IMM rd", rd_ex, 5'd6);
            check_word("OP_IMM op_a", op_a_ex, shadow[7]);
            check_word("OP_IMM imm", imm_ex, expected_imm(ins));
        end
        ins       = $urandom;
        ins[6:0]  = OP_LUI;
        issue(ins, 32'h208, stalls);
        check_word("LUI op_a", op_a_ex, '0);
        check_word("LUI imm", imm_ex, expected_imm(ins));
        check_alu("LUI alu_op", alu_op_ex, expected_alu_op(ins));
        ins[6:0] = OP_AUIPC;
        issue(ins, 32'h0000_2468, stalls);
        check_word("AUIPC op_a", op_a_ex, 32'h0000_2468);
        check_bit("AUIPC reg_wr", reg_wr_ex, expected_reg_wr(ins));
        finish_test("alu decode", e0);
    endtask

    task automatic test_imm_flow();
        int      e0;
        int      i;
        word_t   ins;
        opcode_t ops [3] = '{OP_STORE, OP_LUI, OP_JAL};
        e0 = errors;
        for (i = 0; i < 12; i++) begin
            ins      = $urandom;
            ins[6:0] = ops[i % 3];
            issue(ins, 32'h300, stalls);
            check_word("immediate", imm_ex, expected_imm(ins));
            check_bj("bj_kind", bj_kind_ex, expected_bj_kind(ins));
        end
        for (i = 0; i < 8; i++) begin
            ins        = $urandom;
            ins[14:12] = i[2:0];
            ins[6:0]   = OP_BRANCH;
            issue(ins, 32'h304, stalls);
            check_word("branch imm", imm_ex, expected_imm(ins));
            check_bj("branch kind", bj_kind_ex, expected_bj_kind(ins));
        end
        ins = i_type(OP_JALR, 3'd0, 5'd1, 5'd2, 12'($urandom));
        issue(ins, 32'h308, stalls);
        check_bit("JALR jalr", jalr_ex, 1'b1);
        check_wb("JALR wb_sel", wb_sel_ex, WB_PC4);
        check_word("JALR imm", imm_ex, expected_imm(ins));
        finish_test("imm and flow", e0);
    endtask

    task automatic test_load_use();
        int e0;
        e0 = errors;
        issue(i_type(OP_LOAD, 3'd2, 5'd7, 5'd1, 12'h010), 32'h400, stalls);
        issue(r_type(3'd0, 1'b0, 5'd8, 5'd2, 5'd7), 32'h404, stalls);
        check_bit("rs2 hazard one stall", stalls == 1, 1'b1);
        check_addr("held rd", rd_ex, 5'd8);
        check_word("held pc", pc_ex, 32'h404);
        check_word("held rs2", rs2_data_ex, shadow[7]);
        issue(i_type(OP_LOAD, 3'd2, 5'd7, 5'd1, 12'h010), 32'h408, stalls);
        issue(i_type(OP_IMM, 3'd0, 5'd9, 5'd7, 12'h001), 32'h40c, stalls);
        check_bit("rs1 hazard one stall", stalls == 1, 1'b1);
        check_word("held op_a", op_a_ex, shadow[7]);
        issue(i_type(OP_LOAD, 3'd2, 5'd0, 5'd1, 12'h010), 32'h410, stalls);
        issue(r_type(3'd0, 1'b0, 5'd8, 5'd0, 5'd0), 32'h414, stalls);
        check_bit("x0 load no stall", stalls == 0, 1'b1);
        finish_test("load-use", e0);
    endtask

    task automatic test_mem_flush_illegal();
        int         e0;
        int         i;
        word_t      ins;
        logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        word_t      bad [2] = '{32'h0ff0_000f, 32'h0000_0073};
        e0 = errors;
        for (i = 0; i < 5; i++) begin
            issue(i_type(OP_LOAD, load_f3[i], 5'd10, 5'd1, 12'h004), 32'h500, stalls);
            check_width("load width", mem_width_ex, load_f3[i][1:0]);
            check_bit("load unsigned", mem_unsigned_ex, load_f3[i][2]);
            check_bit("load mem_rd", mem_rd_ex, 1'b1);
            check_wb("load wb_sel", wb_sel_ex, WB_MEM);
        end
        for (i = 0; i < 3; i++) begin
            ins        = $urandom;
            ins[14:12] = i[2:0];
            ins[6:0]   = OP_STORE;
            issue(ins, 32'h504, stalls);
            check_width("store width", mem_width_ex, i[1:0]);
            check_bit("store mem_wr", mem_wr_ex, 1'b1);
            check_bit("store reg_wr", reg_wr_ex, 1'b0);
        end
        flush = 1'b1;
        issue(r_type(3'd0, 1'b0, 5'd3, 5'd4, 5'd5), 32'h508, stalls);
        flush = 1'b0;
        check_ex_cleared("flush");
        for (i = 0; i < 2; i++) begin
            issue(bad[i], 32'h50c, stalls);
            check_bit("illegal", illegal_ex, 1'b1);
            check_bit("illegal enables", |{reg_wr_ex, mem_rd_ex, mem_wr_ex, jalr_ex, use_imm_ex},
                      1'b0);
        end
        finish_test("mem/flush/ill", e0);
    endtask

    initial begin
        int seed_draw;
        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        instr     = 32'h0000_0013;
        pc        = '0;
        wb_we     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        checks    = 0;
        errors    = 0;
        shadow    = '{default: '0};
        seed_draw = $urandom(32'h44c41826);
        test_reset();
        test_regfile();
        test_alu_decode();
        test_imm_flow();
        test_load_use();
        test_mem_flush_illegal();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
hw/core_pkg.sv
hw/ex_ctrl_if.sv
hw/register_file.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/load_use_detect.sv
hw/decode_stage.sv
hw/decode_top.sv
dv/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hw/core_pkg.sv
  - hw/ex_ctrl_if.sv
  - hw/register_file.sv
  - hw/instr_decoder.sv
  - hw/imm_gen.sv
  - hw/load_use_detect.sv
  - hw/decode_stage.sv
  - hw/decode_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_decode_top.sv
